/* hdl/pmp_consts.svh */
// ----------------------------------------------------------------------
// Sizes for the eight-entry PMP CSR block. pmpcfg2 and the upper
// pmpaddr CSRs are not implemented, so the entry count is fixed at 8.
// ----------------------------------------------------------------------
`ifndef PMP_CONSTS_SVH
`define PMP_CONSTS_SVH

// Number of PMP entries held in state
`define PMP_ENTRIES 8

// CSR data word width
`define PMP_XLEN 64

// Stored address width and the lowest stored bit of the CSR write word
`define PMP_ADDR_WIDTH 29
`define PMP_ADDR_LSB 9

// One configuration byte per entry inside pmpcfg0
`define PMP_CFG_BITS 8

// Readable CSRs
// Select bit 0 is pmpcfg0, bits 1 to 8 are pmpaddr0 to pmpaddr7
`define PMP_CSR_COUNT 9

`endif

/* hdl/pmp_cfg_pkg.sv */
// ----------------------------------------------------------------------
// PMP configuration types. One entry matches the pmpcfg byte layout.
// ----------------------------------------------------------------------
`default_nettype none

`include "pmp_consts.svh"

package pmp_cfg_pkg;

  // ---------------------------------------------------------------------
  // Address matching mode, bits 4:3 of a configuration byte
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {
    pmp_off   = 2'd0,
    pmp_tor   = 2'd1,
    pmp_na4   = 2'd2,
    pmp_napot = 2'd3
  } pmp_addr_mode_t;

  // ---------------------------------------------------------------------
  // One configuration byte, highest bit first
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic           lock;
    // Reserved, always zero in stored state
    logic [1:0]     rsvd;
    pmp_addr_mode_t addr_mode;
    logic           executable;
    logic           writable;
    logic           readable;
  } pmp_cfg_entry_t;

  // Whole pmpcfg0 word, entry i in byte i
  typedef pmp_cfg_entry_t [`PMP_ENTRIES-1:0] pmp_cfg_vec_t;

endpackage

`default_nettype wire

/* hdl/pmp_csr_pkg.sv */
// ----------------------------------------------------------------------
// CSR side types: data words, read select and stored PMP addresses
// ----------------------------------------------------------------------
`default_nettype none

`include "pmp_consts.svh"

package pmp_csr_pkg;

  // One CSR data word as seen on the read and write buses
  typedef logic [`PMP_XLEN-1:0] pmp_word_t;

  // Stored address, write word bits 37:9
  typedef logic [`PMP_ADDR_WIDTH-1:0] pmp_addr_t;

  // All stored addresses, entry i at index i
  typedef pmp_addr_t [`PMP_ENTRIES-1:0] pmp_addr_vec_t;

  // One-hot or multi-hot read select
  // bit 0 pmpcfg0, bit i+1 pmpaddr i
  typedef logic [`PMP_CSR_COUNT-1:0] pmp_csr_sel_t;

  // Per-entry flags, write strobes and locks
  typedef logic [`PMP_ENTRIES-1:0] pmp_entry_mask_t;

endpackage

`default_nettype wire

/* hdl/pmp_cfg_bank.sv */
// ----------------------------------------------------------------------
// Lockable pmpcfg0 entries. A lock only clears on reset, and entry 7
// has no TOR neighbor since pmpcfg2 is not implemented.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "pmp_consts.svh"

module pmp_cfg_bank (
  input  wire                            cpuclk,
  input  wire                            cpurst_b,
  input  wire pmp_csr_pkg::pmp_word_t    wdata,
  input  wire                            cfg_wen,
  output wire pmp_cfg_pkg::pmp_cfg_vec_t cfg_value,
  output wire pmp_csr_pkg::pmp_entry_mask_t addr_lock
);

  import pmp_cfg_pkg::*;

  // --------------------------------------------------------------------
  // Configuration entries
  // --------------------------------------------------------------------
  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_entry
    pmp_cfg_entry_t wr_byte;
    pmp_cfg_entry_t entry_q;
    logic           entry_upd;

    // Byte i of the write word, reserved field cleared
    always_comb
    begin
      wr_byte      = wdata[i*`PMP_CFG_BITS +: `PMP_CFG_BITS];
      wr_byte.rsvd = 2'b00;
    end

    // Locked entries ignore pmpcfg0 writes
    assign entry_upd = cfg_wen && !entry_q.lock;

    always_ff @(posedge cpuclk or negedge cpurst_b)
    begin
      if (!cpurst_b)
      begin
        entry_q <= '0;
      end
      else if (entry_upd)
      begin
        entry_q <= wr_byte;
      end
    end

    assign cfg_value[i] = entry_q;

    // ------------------------------------------------------------------
    // Address lock
    // ------------------------------------------------------------------
    // A locked TOR entry above also protects this address, since
    // it is the bottom of that entry's range
    if (i == `PMP_ENTRIES - 1)
    begin : g_last
      assign addr_lock[i] = entry_q.lock;
    end
    else
    begin : g_mid
      assign addr_lock[i] = entry_q.lock
                          | (cfg_value[i+1].lock
                             & (cfg_value[i+1].addr_mode == pmp_tor));
    end
  end

endmodule

`default_nettype wire

/* hdl/pmp_addr_bank.sv */
// ----------------------------------------------------------------------
// pmpaddr0 to pmpaddr7 storage. Only write word bits 37:9 are kept.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "pmp_consts.svh"

module pmp_addr_bank (
  input  wire                               cpuclk,
  input  wire                               cpurst_b,
  input  wire pmp_csr_pkg::pmp_word_t       wdata,
  input  wire pmp_csr_pkg::pmp_entry_mask_t addr_wen,
  input  wire pmp_csr_pkg::pmp_entry_mask_t addr_lock,
  output wire pmp_csr_pkg::pmp_addr_vec_t   addr_value
);

  import pmp_csr_pkg::*;

  pmp_addr_t       wr_addr;
  pmp_entry_mask_t addr_upd;

  // Same slice feeds every entry
  assign wr_addr = wdata[`PMP_ADDR_LSB +: `PMP_ADDR_WIDTH];

  // Lock comes from the configuration before this edge
  assign addr_upd = addr_wen & ~addr_lock;

  // --------------------------------------------------------------------
  // Address registers
  // --------------------------------------------------------------------
  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_addr
    pmp_addr_t addr_q;

    always_ff @(posedge cpuclk or negedge cpurst_b)
    begin
      if (!cpurst_b)
      begin
        addr_q <= '0;
      end
      else if (addr_upd[i])
      begin
        addr_q <= wr_addr;
      end
    end

    assign addr_value[i] = addr_q;
  end

endmodule

`default_nettype wire

/* hdl/pmp_csr_read.sv */
// ----------------------------------------------------------------------
// Combinational CSR readback. Several select bits may be set and the
// selected values are ORed together.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "pmp_consts.svh"

module pmp_csr_read (
  input  wire pmp_csr_pkg::pmp_csr_sel_t  csr_sel,
  input  wire pmp_cfg_pkg::pmp_cfg_vec_t  cfg_value,
  input  wire pmp_csr_pkg::pmp_addr_vec_t addr_value,
  output pmp_csr_pkg::pmp_word_t          csr_rdata
);

  import pmp_csr_pkg::*;

  pmp_word_t addr_word [`PMP_ENTRIES];

  // --------------------------------------------------------------------
  // Address realignment
  // --------------------------------------------------------------------
  // Stored bits go back to 37:9, all other bits read zero
  always_comb
  begin
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      addr_word[i] = pmp_word_t'(addr_value[i]) << `PMP_ADDR_LSB;
    end
  end

  // --------------------------------------------------------------------
  // OR of the selected sources
  // --------------------------------------------------------------------
  always_comb
  begin
    csr_rdata = {`PMP_XLEN{csr_sel[0]}} & cfg_value;
    for (int s = 1; s < `PMP_CSR_COUNT; s++)
    begin
      csr_rdata = csr_rdata | ({`PMP_XLEN{csr_sel[s]}} & addr_word[s-1]);
    end
  end

endmodule

`default_nettype wire

/* hdl/pmp_regs.sv */
// ----------------------------------------------------------------------
// PMP CSR state for 8 entries. Writes are single-cycle strobes with no
// acknowledge, and readback is combinational.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "pmp_consts.svh"

module pmp_regs (
  input  wire                               cpuclk,
  input  wire                               cpurst_b,
  input  wire pmp_csr_pkg::pmp_word_t       wdata,
  input  wire                               cfg_wen,
  input  wire pmp_csr_pkg::pmp_entry_mask_t addr_wen,
  input  wire pmp_csr_pkg::pmp_csr_sel_t    csr_sel,
  output wire pmp_csr_pkg::pmp_word_t       csr_rdata,
  output wire pmp_cfg_pkg::pmp_cfg_vec_t    pmpcfg0_value,
  output wire pmp_csr_pkg::pmp_addr_vec_t   pmpaddr_value
);

  import pmp_cfg_pkg::*;
  import pmp_csr_pkg::*;

  wire pmp_cfg_vec_t    cfg_value;
  wire pmp_entry_mask_t addr_lock;
  wire pmp_addr_vec_t   addr_value;

  // --------------------------------------------------------------------
  // Configuration and address state
  // --------------------------------------------------------------------
  pmp_cfg_bank u_cfg_bank (
    .cpuclk    (cpuclk),
    .cpurst_b  (cpurst_b),
    .wdata     (wdata),
    .cfg_wen   (cfg_wen),
    .cfg_value (cfg_value),
    .addr_lock (addr_lock)
  );

  // Same-cycle cfg and addr writes see the old locks
  pmp_addr_bank u_addr_bank (
    .cpuclk     (cpuclk),
    .cpurst_b   (cpurst_b),
    .wdata      (wdata),
    .addr_wen   (addr_wen),
    .addr_lock  (addr_lock),
    .addr_value (addr_value)
  );

  // --------------------------------------------------------------------
  // Readback
  // --------------------------------------------------------------------
  pmp_csr_read u_csr_read (
    .csr_sel    (csr_sel),
    .cfg_value  (cfg_value),
    .addr_value (addr_value),
    .csr_rdata  (csr_rdata)
  );

  assign pmpcfg0_value = cfg_value;
  assign pmpaddr_value = addr_value;

endmodule

`default_nettype wire

/* bench/pmp_regs_assertions.sv */
// ----------------------------------------------------------------------
// Bound into pmp_regs. Lock checks are off while reset is low.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "pmp_consts.svh"

module pmp_regs_assertions (
  input wire                               cpuclk,
  input wire                               cpurst_b,
  input wire pmp_csr_pkg::pmp_csr_sel_t    csr_sel,
  input wire pmp_csr_pkg::pmp_word_t       csr_rdata,
  input wire pmp_csr_pkg::pmp_entry_mask_t addr_lock,
  input wire pmp_cfg_pkg::pmp_cfg_vec_t    pmpcfg0_value,
  input wire pmp_csr_pkg::pmp_addr_vec_t   pmpaddr_value
);

  // --------------------------------------------------------------------
  // Per-entry lock stability
  // --------------------------------------------------------------------
  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_entry
    // Lock sampled before the edge blocks the write at that edge
    addr_hold : assert property (
      @(posedge cpuclk) disable iff (!cpurst_b)
      addr_lock[i] |=> $stable(pmpaddr_value[i]))
      else $error("pmpaddr%0d changed while its address lock was set", i);

    cfg_hold : assert property (
      @(posedge cpuclk) disable iff (!cpurst_b)
      pmpcfg0_value[i].lock |=> $stable(pmpcfg0_value[i]))
      else $error("pmpcfg0 byte %0d changed while locked", i);
  end

  // Nothing selected reads as zero
  idle_read : assert property (
    @(posedge cpuclk) (csr_sel == '0) |-> (csr_rdata == '0))
    else $error("csr_rdata is not zero with no CSR selected");

endmodule

`default_nettype wire

/* bench/pmp_regs_tb.sv */
// ----------------------------------------------------------------------
// Testbench for pmp_regs. The model updates on the rising edge and the
// DUT is compared on every falling edge, including during reset.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "pmp_consts.svh"

module pmp_regs_tb;

  import pmp_cfg_pkg::*;
  import pmp_csr_pkg::*;

  localparam pmp_word_t lock_bits = 64'h8080_8080_8080_8080;
  localparam pmp_word_t rsvd_bits = 64'h6060_6060_6060_6060;
  // Write word bits 37:9
  localparam pmp_word_t addr_bits = 64'h0000_003f_ffff_fe00;

  logic            cpuclk = 1'b0;
  logic            cpurst_b;
  pmp_word_t       wdata;
  logic            cfg_wen;
  pmp_entry_mask_t addr_wen;
  pmp_csr_sel_t    csr_sel;
  wire pmp_word_t     csr_rdata;
  wire pmp_cfg_vec_t  pmpcfg0_value;
  wire pmp_addr_vec_t pmpaddr_value;

  pmp_cfg_vec_t    model_cfg = '0;
  pmp_addr_vec_t   model_addr = '0;
  integer          seed = 96445;
  int              check_count = 0;
  string           test_name = "init";

  always #50 cpuclk = ~cpuclk;

  pmp_regs dut0 (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .wdata         (wdata),
    .cfg_wen       (cfg_wen),
    .addr_wen      (addr_wen),
    .csr_sel       (csr_sel),
    .csr_rdata     (csr_rdata),
    .pmpcfg0_value (pmpcfg0_value),
    .pmpaddr_value (pmpaddr_value)
  );

  bind pmp_regs pmp_regs_assertions u_assertions (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .csr_sel       (csr_sel),
    .csr_rdata     (csr_rdata),
    .addr_lock     (addr_lock),
    .pmpcfg0_value (pmpcfg0_value),
    .pmpaddr_value (pmpaddr_value)
  );

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------
  function automatic pmp_cfg_vec_t next_cfg(pmp_cfg_vec_t cfg, pmp_word_t data);
    pmp_cfg_vec_t nxt;
    nxt = cfg;
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      // Bits 6:5 of every byte are reserved
      if (!cfg[i].lock)
      begin
        nxt[i] = data[i*8 +: 8] & 8'h9f;
      end
    end
    return nxt;
  endfunction

  function automatic pmp_addr_vec_t next_addr(pmp_cfg_vec_t cfg, pmp_addr_vec_t addr,
                                              pmp_word_t data, pmp_entry_mask_t wen);
    pmp_addr_vec_t nxt;
    logic          blocked;
    nxt = addr;
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      blocked = cfg[i].lock;
      if (i < `PMP_ENTRIES - 1)
      begin
        // Locked TOR entry above uses this address as its base
        if (cfg[i+1].lock && cfg[i+1].addr_mode == pmp_tor)
        begin
          blocked = 1'b1;
        end
      end
      if (wen[i] && !blocked)
      begin
        nxt[i] = data[37:9];
      end
    end
    return nxt;
  endfunction

  function automatic pmp_word_t expected_rdata(pmp_csr_sel_t sel, pmp_cfg_vec_t cfg,
                                               pmp_addr_vec_t addr);
    pmp_word_t w;
    w = '0;
    if (sel[0])
    begin
      w = w | cfg;
    end
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      if (sel[i+1])
      begin
        w[37:9] = w[37:9] | addr[i];
      end
    end
    return w;
  endfunction

  function automatic pmp_word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // --------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------
  task automatic stop_on_failure();
    $display("Test FAILED");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic check_cfg(input string what, input pmp_cfg_vec_t exp,
                           input pmp_cfg_vec_t act);
    if (act !== exp)
    begin
      $display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_addr(input string what, input pmp_addr_vec_t exp,
                            input pmp_addr_vec_t act);
    if (act !== exp)
    begin
      $display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_rdata(input string what, input pmp_word_t exp, input pmp_word_t act);
    if (act !== exp)
    begin
      $display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  // Address writes see the configuration from before this edge
  always @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      model_cfg  = '0;
      model_addr = '0;
    end
    else
    begin
      model_addr = next_addr(model_cfg, model_addr, wdata, addr_wen);
      if (cfg_wen)
      begin
        model_cfg = next_cfg(model_cfg, wdata);
      end
    end
  end

  always @(negedge cpuclk)
  begin
    check_cfg("pmpcfg0_value", model_cfg, pmpcfg0_value);
    check_addr("pmpaddr_value", model_addr, pmpaddr_value);
    check_rdata("csr_rdata", expected_rdata(csr_sel, model_cfg, model_addr), csr_rdata);
    check_count++;
  end

  // --------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------
  task automatic hold_reset();
    for (int n = 0; n < 16; n++)
    begin
      @(posedge cpuclk);
    end
    cpurst_b <= 1'b1;
  endtask

  task automatic apply_reset();
    @(posedge cpuclk);
    cpurst_b <= 1'b0;
    hold_reset();
  endtask

  task automatic issue_write(input logic cfg_en, input pmp_entry_mask_t addr_en,
                             input pmp_word_t data);
    @(posedge cpuclk);
    wdata    <= data;
    cfg_wen  <= cfg_en;
    addr_wen <= addr_en;
  endtask

  task automatic end_writes();
    @(posedge cpuclk);
    cfg_wen  <= 1'b0;
    addr_wen <= '0;
  endtask

  task automatic select_read(input pmp_csr_sel_t sel);
    @(posedge cpuclk);
    csr_sel <= sel;
  endtask

  task automatic wait_checks(input int n);
    int start;
    int cycles;
    start  = check_count;
    cycles = 0;
    while (check_count < start + n)
    begin
      @(posedge cpuclk);
      cycles++;
      if (cycles > n + 8)
      begin
        $display("Timeout: the compare process stopped checking the DUT");
        stop_on_failure();
      end
    end
  endtask

  // --------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------
  initial
  begin
    pmp_cfg_entry_t held_byte;
    pmp_word_t      data;
    pmp_word_t      last;
    cpurst_b <= 1'b0;
    wdata    <= '0;
    cfg_wen  <= 1'b0;
    addr_wen <= '0;
    csr_sel  <= '0;
    hold_reset();

    test_name = "reset_state";
    for (int s = 0; s < `PMP_CSR_COUNT; s++)
    begin
      select_read(pmp_csr_sel_t'(1) << s);
    end
    select_read('0);
    wait_checks(2);

    test_name = "cfg_write";
    select_read(pmp_csr_sel_t'(1));
    for (int n = 0; n < 8; n++)
    begin
      issue_write(1'b1, '0, rand_word() & ~lock_bits);
    end
    end_writes();
    wait_checks(2);
    @(negedge cpuclk);
    check_rdata("reserved bits in csr_rdata", '0, csr_rdata & rsvd_bits);
    check_cfg("reserved bits in pmpcfg0_value", '0, pmpcfg0_value & rsvd_bits);

    // Byte 2 locked, then only a reset releases it
    test_name = "cfg_lock";
    data = (rand_word() & ~lock_bits) | 64'h0000_0000_0080_0000;
    issue_write(1'b1, '0, data);
    end_writes();
    wait_checks(1);
    @(negedge cpuclk);
    // Byte 2 as written, reserved bits cleared
    held_byte = data[23:16] & 8'h9f;
    for (int n = 0; n < 4; n++)
    begin
      issue_write(1'b1, '0, rand_word() & ~lock_bits);
    end
    end_writes();
    wait_checks(1);
    @(negedge cpuclk);
    check_rdata("locked byte 2", pmp_word_t'(held_byte), pmp_word_t'(pmpcfg0_value[2]));
    apply_reset();
    issue_write(1'b1, '0, rand_word() & ~lock_bits);
    end_writes();
    wait_checks(2);

    test_name = "addr_write";
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      issue_write(1'b0, pmp_entry_mask_t'(1) << i, rand_word());
    end
    end_writes();
    for (int s = 1; s < `PMP_CSR_COUNT; s++)
    begin
      select_read(pmp_csr_sel_t'(1) << s);
      @(negedge cpuclk);
      check_rdata("bits outside 37:9", '0, csr_rdata & ~addr_bits);
    end

    // Entry 3 TOR locked, entry 5 NAPOT locked, entry 7 locked
    test_name = "addr_lock";
    apply_reset();
    data = rand_word() & ~lock_bits;
    data[63:56] = 8'h80;
    data[47:40] = 8'h98;
    data[31:24] = 8'h88;
    issue_write(1'b1, 8'hff, data);
    last = '0;
    for (int n = 0; n < 3; n++)
    begin
      last = rand_word();
      issue_write(1'b0, 8'hff, last);
    end
    end_writes();
    wait_checks(2);
    @(negedge cpuclk);
    check_rdata("pmpaddr2 below TOR lock", pmp_word_t'(data[37:9]),
                pmp_word_t'(pmpaddr_value[2]));
    check_rdata("pmpaddr4 below NAPOT lock", pmp_word_t'(last[37:9]),
                pmp_word_t'(pmpaddr_value[4]));
    check_rdata("pmpaddr7 own lock", pmp_word_t'(data[37:9]), pmp_word_t'(pmpaddr_value[7]));

    test_name = "multi_select";
    for (int n = 0; n < 8; n++)
    begin
      select_read(pmp_csr_sel_t'($random(seed)));
    end
    select_read('1);
    select_read('0);
    wait_checks(2);

    $display("Test OK");
    $finish;
  end

  initial
  begin
    #1_000_000;
    $display("Simulation did not finish within its time limit");
    stop_on_failure();
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/pmp_cfg_pkg.sv
hdl/pmp_csr_pkg.sv
hdl/pmp_cfg_bank.sv
hdl/pmp_addr_bank.sv
hdl/pmp_csr_read.sv
hdl/pmp_regs.sv
bench/pmp_regs_assertions.sv
bench/pmp_regs_tb.sv

/* Makefile */
# Verilator build for the PMP CSR testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pmp_regs_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
